// ==== hw/dsi3_macros.svh ====
//************************************************************
// Build-time constants of the DSI3 PDCM timing subsystem
// Tick divider, timeout offset, channel count, log depth
//************************************************************

`ifndef DSI3_MACROS_SVH
`define DSI3_MACROS_SVH

// System clocks per 1 us prescaler tick
`define DSI3_TICK_DIV 18

// Remaining microseconds at which the receive timeout fires
`define DSI3_TIMEOUT_US 5

// Peer channels sharing the event log
`define DSI3_CHANNELS 2

// Entries held by the event log
`define DSI3_LOG_DEPTH 16

`endif

// ==== hw/dsi3_pkg.sv ====
//************************************************************
// Shared types of the DSI3 PDCM timing subsystem
// Vector typedefs, config and event structs, sequencer states
//************************************************************

`default_nettype none

package dsi3_pkg;

	// Period length in microseconds
	typedef logic [15:0] data_t;

	// Period index inside a frame, also the periods per frame
	typedef logic [7:0] frame_idx_t;

	// Channel number
	typedef logic [0:0] chan_t;

	// Host frame configuration, 24 bits
	typedef struct packed {
		data_t      period_us;
		frame_idx_t frame_count;
	} pdcm_cfg_t;

	// One log entry per PDCM period, 10 bits
	typedef struct packed {
		chan_t      channel;
		frame_idx_t index;
		logic       rx_seen;
	} pdcm_event_t;

	// Channel sequencer states
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		NEXT
	} seq_state_t;

endpackage

`default_nettype wire

// ==== hw/period_counter.sv ====
//************************************************************
// PDCM period timer
// 1 us prescaler, period down-counter, receive timeout pulse
//************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "dsi3_macros.svh"

module period_counter (
	input  logic             clk_rst,
	input  logic             i_rst_n,
	input  dsi3_pkg::data_t  i_new_period_value,
	input  logic             i_start,
	input  logic             i_stop,
	output logic             o_receive_timeout,
	output logic             o_running
);

	typedef logic [4:0] tick_cnt_t;

	localparam tick_cnt_t TICK_LAST = tick_cnt_t'(`DSI3_TICK_DIV - 1);

	tick_cnt_t       tick_cnt;
	tick_cnt_t       tick_cnt_nxt;
	logic            tick_1us;
	logic            tick_early;
	logic            running;
	logic            running_nxt;
	dsi3_pkg::data_t period_cnt;
	dsi3_pkg::data_t period_cnt_nxt;

	// Prescaler only counts inside a running period
	assign tick_1us   = running && (tick_cnt == TICK_LAST);
	assign tick_early = running && (tick_cnt == TICK_LAST - tick_cnt_t'(1));

	always_comb begin
		if (i_start || !running || tick_1us)
			tick_cnt_nxt = '0;
		else
			tick_cnt_nxt = tick_cnt + tick_cnt_t'(1);
	end

	always_comb begin
		period_cnt_nxt = period_cnt;
		if (i_start || i_stop)
			period_cnt_nxt = i_new_period_value - dsi3_pkg::data_t'(1);
		else if (tick_1us && (period_cnt > '0))
			period_cnt_nxt = period_cnt - dsi3_pkg::data_t'(1);
	end

	// Running drops one clock before the last tick so the period ends on the boundary
	always_comb begin
		running_nxt = running;
		if ((period_cnt == '0) && tick_early)
			running_nxt = 1'b0;
		if (i_start)
			running_nxt = 1'b1;
		if (i_stop)
			running_nxt = 1'b0;
	end

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			tick_cnt   <= '0;
			running    <= 1'b0;
			period_cnt <= '0;
		end else begin
			tick_cnt   <= tick_cnt_nxt;
			running    <= running_nxt;
			period_cnt <= period_cnt_nxt;
		end
	end

	assign o_running         = running;
	assign o_receive_timeout = tick_1us && (period_cnt == dsi3_pkg::data_t'(`DSI3_TIMEOUT_US));

	// The sequencer never restarts and stops a period together
	a_start_stop_excl: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		!(i_start && i_stop))
		else $error("period_counter: start and stop in the same cycle");

endmodule

`default_nettype wire

// ==== hw/pdcm_sequencer.sv ====
//************************************************************
// Per-channel PDCM frame sequencer
// Period start control, rx tracking, event log requests
//************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "dsi3_macros.svh"

module pdcm_sequencer (
	input  logic                  clk_rst,
	input  logic                  i_rst_n,
	input  dsi3_pkg::chan_t       i_chan,
	input  dsi3_pkg::pdcm_cfg_t   i_cfg,
	input  logic                  i_frame_start,
	input  logic                  i_abort,
	input  logic                  i_rx_strobe,
	input  logic                  i_evt_grant,
	output logic                  o_busy,
	output logic                  o_evt_req,
	output dsi3_pkg::pdcm_event_t o_evt
);

	dsi3_pkg::seq_state_t  state;
	dsi3_pkg::seq_state_t  state_nxt;
	dsi3_pkg::pdcm_cfg_t   cfg_q;
	dsi3_pkg::frame_idx_t  idx;
	dsi3_pkg::pdcm_event_t evt_now;
	dsi3_pkg::pdcm_event_t evt_q;
	logic                  start;
	logic                  stop;
	logic                  running;
	logic                  timeout;
	logic                  last_period;
	logic                  frame_go;
	logic                  period_end;
	logic                  rx_flag;
	logic                  req_q;

	assign frame_go    = (state == dsi3_pkg::IDLE) && i_frame_start;
	assign period_end  = (state == dsi3_pkg::RUN) && !running;
	assign start       = (state == dsi3_pkg::NEXT) && !i_abort;
	assign stop        = i_abort && (state != dsi3_pkg::IDLE);
	assign last_period = dsi3_pkg::frame_idx_t'(idx + 1'b1) >= cfg_q.frame_count;

	period_counter u_period_counter (
		.clk_rst            (clk_rst),
		.i_rst_n            (i_rst_n),
		.i_new_period_value (cfg_q.period_us),
		.i_start            (start),
		.i_stop             (stop),
		.o_receive_timeout  (timeout),
		.o_running          (running)
	);

	always_comb begin
		state_nxt = state;
		case (state)
			dsi3_pkg::IDLE: if (i_frame_start) state_nxt = dsi3_pkg::NEXT;
			dsi3_pkg::NEXT: state_nxt = dsi3_pkg::RUN;
			dsi3_pkg::RUN:  if (!running) state_nxt = last_period ? dsi3_pkg::IDLE : dsi3_pkg::NEXT;
			default:        state_nxt = dsi3_pkg::IDLE;
		endcase
		// Abort wins over everything
		if (i_abort)
			state_nxt = dsi3_pkg::IDLE;
	end

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			state   <= dsi3_pkg::IDLE;
			idx     <= '0;
			rx_flag <= 1'b0;
			req_q   <= 1'b0;
		end else begin
			state <= state_nxt;
			if (frame_go)
				idx <= '0;
			else if (period_end && !last_period)
				idx <= idx + 1'b1;
			// Sticky rx flag, restarted with every period
			if (start)
				rx_flag <= i_rx_strobe;
			else if (i_rx_strobe)
				rx_flag <= 1'b1;
			// Hold the request until the arbiter takes it
			req_q <= (req_q || timeout) && !i_evt_grant;
		end
	end

	always_ff @(posedge clk_rst) begin
		if (frame_go)
			cfg_q <= i_cfg;
		if (timeout)
			evt_q <= evt_now;
	end

	always_comb begin
		evt_now.channel = i_chan;
		evt_now.index   = idx;
		evt_now.rx_seen = rx_flag || i_rx_strobe;
	end

	// Timeout requests right away to keep the log latency short
	assign o_evt_req = req_q || timeout;
	assign o_evt     = req_q ? evt_q : evt_now;
	assign o_busy    = (state != dsi3_pkg::IDLE);

	a_no_timeout_pending: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		timeout |-> !req_q)
		else $error("pdcm_sequencer: timeout with a request still pending");

	a_min_period: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		(frame_go && !i_abort) |-> (i_cfg.period_us > dsi3_pkg::data_t'(`DSI3_TIMEOUT_US)))
		else $error("pdcm_sequencer: period shorter than the timeout window");

endmodule

`default_nettype wire

// ==== hw/event_arbiter.sv ====
//************************************************************
// Round-robin arbiter onto the event log write port
//************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "dsi3_macros.svh"

module event_arbiter (
	input  logic                                       clk_rst,
	input  logic                                       i_rst_n,
	input  logic                  [`DSI3_CHANNELS-1:0] i_req,
	input  dsi3_pkg::pdcm_event_t [`DSI3_CHANNELS-1:0] i_evt,
	output logic                  [`DSI3_CHANNELS-1:0] o_grant,
	output logic                                       o_wr_en,
	output dsi3_pkg::pdcm_event_t                      o_wr_evt
);

	localparam int N     = `DSI3_CHANNELS;
	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] sel;
	logic             found;

	// First requester at or after the pointer
	always_comb begin
		int cand;
		cand    = 0;
		sel     = ptr;
		found   = 1'b0;
		o_grant = '0;
		for (int k = 0; k < N; k++) begin
			cand = (int'(ptr) + k) % N;
			if (!found && i_req[cand]) begin
				found         = 1'b1;
				sel           = PTR_W'(cand);
				o_grant[cand] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			ptr     <= '0;
			o_wr_en <= 1'b0;
		end else begin
			o_wr_en <= found;
			if (found)
				ptr <= PTR_W'((int'(sel) + 1) % N);
		end
	end

	always_ff @(posedge clk_rst) begin
		if (found)
			o_wr_evt <= i_evt[sel];
	end

	// Exactly one requester wins whenever any asks
	a_grant_valid: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		$onehot0(o_grant) && ((o_grant & ~i_req) == '0) && ((|i_req) == (|o_grant)))
		else $error("event_arbiter: grant does not match requests");

endmodule

`default_nettype wire

// ==== hw/event_log.sv ====
//************************************************************
// Event log, first-word-fall-through circular buffer
// Host read strobe, sticky overflow on write to a full log
//************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "dsi3_macros.svh"

module event_log (
	input  logic                  clk_rst,
	input  logic                  i_rst_n,
	input  logic                  i_wr_en,
	input  dsi3_pkg::pdcm_event_t i_wr_evt,
	input  logic                  i_rd_en,
	output dsi3_pkg::pdcm_event_t o_rd_evt,
	output logic                  o_rd_valid,
	output logic                  o_overflow
);

	localparam int DEPTH = `DSI3_LOG_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	dsi3_pkg::pdcm_event_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          do_wr;
	logic          do_rd;

	assign full  = (count == (AW+1)'(DEPTH));
	assign do_wr = i_wr_en && !full;
	assign do_rd = i_rd_en && o_rd_valid;

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Entry lost, flag stays until reset
			if (i_wr_en && full)
				o_overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk_rst) begin
		if (do_wr)
			mem[wr_ptr] <= i_wr_evt;
	end

	// Oldest entry is always on the output
	assign o_rd_evt   = mem[rd_ptr];
	assign o_rd_valid = (count != '0);

	a_no_empty_read: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		i_rd_en |-> o_rd_valid)
		else $error("event_log: host read while the log is empty");

endmodule

`default_nettype wire

// ==== hw/dsi3_pdcm_top.sv ====
//************************************************************
// DSI3 PDCM timing top level
// Channel sequencers, round-robin arbiter, event log
//************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "dsi3_macros.svh"

module dsi3_pdcm_top (
	input  logic                       clk_rst,
	input  logic                       i_rst_n,
	input  dsi3_pkg::pdcm_cfg_t        i_cfg,
	input  logic [`DSI3_CHANNELS-1:0]  i_frame_start,
	input  logic [`DSI3_CHANNELS-1:0]  i_abort,
	input  logic [`DSI3_CHANNELS-1:0]  i_rx_strobe,
	input  logic                       i_rd_en,
	output logic [`DSI3_CHANNELS-1:0]  o_busy,
	output dsi3_pkg::pdcm_event_t      o_rd_evt,
	output logic                       o_rd_valid,
	output logic                       o_overflow
);

	logic                  [`DSI3_CHANNELS-1:0] evt_req;
	logic                  [`DSI3_CHANNELS-1:0] evt_grant;
	dsi3_pkg::pdcm_event_t [`DSI3_CHANNELS-1:0] evt;
	logic                                       wr_en;
	dsi3_pkg::pdcm_event_t                      wr_evt;

	// One sequencer per channel, numbered by its slot
	for (genvar g = 0; g < `DSI3_CHANNELS; g++) begin : g_chan
		pdcm_sequencer u_seq (
			.clk_rst       (clk_rst),
			.i_rst_n       (i_rst_n),
			.i_chan        (dsi3_pkg::chan_t'(g)),
			.i_cfg         (i_cfg),
			.i_frame_start (i_frame_start[g]),
			.i_abort       (i_abort[g]),
			.i_rx_strobe   (i_rx_strobe[g]),
			.i_evt_grant   (evt_grant[g]),
			.o_busy        (o_busy[g]),
			.o_evt_req     (evt_req[g]),
			.o_evt         (evt[g])
		);
	end

	event_arbiter u_arbiter (
		.clk_rst  (clk_rst),
		.i_rst_n  (i_rst_n),
		.i_req    (evt_req),
		.i_evt    (evt),
		.o_grant  (evt_grant),
		.o_wr_en  (wr_en),
		.o_wr_evt (wr_evt)
	);

	event_log u_log (
		.clk_rst    (clk_rst),
		.i_rst_n    (i_rst_n),
		.i_wr_en    (wr_en),
		.i_wr_evt   (wr_evt),
		.i_rd_en    (i_rd_en),
		.o_rd_evt   (o_rd_evt),
		.o_rd_valid (o_rd_valid),
		.o_overflow (o_overflow)
	);

endmodule

`default_nettype wire

// ==== sim/tb_dsi3_pdcm.sv ====
//************************************************************
// Directed testbench for the DSI3 PDCM timing top level
// Reference event queues, log drain, watchdog, summary
//************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "dsi3_macros.svh"

module tb_dsi3_pdcm;

	localparam int US_CYCLES = `DSI3_TICK_DIV;
	localparam int PERIOD_US = 12;
	// One event per period, so two periods bound the wait for the next one
	localparam int EVT_WAIT  = 2 * PERIOD_US * US_CYCLES;
	// Summed frame lengths of all tests are near 5000 cycles
	localparam int WATCHDOG_CYCLES = 25000;

	logic                      clk_rst;
	logic                      i_rst_n;
	dsi3_pkg::pdcm_cfg_t       i_cfg;
	logic [`DSI3_CHANNELS-1:0] i_frame_start;
	logic [`DSI3_CHANNELS-1:0] i_abort;
	logic [`DSI3_CHANNELS-1:0] i_rx_strobe;
	logic                      i_rd_en;
	logic [`DSI3_CHANNELS-1:0] o_busy;
	dsi3_pkg::pdcm_event_t     o_rd_evt;
	logic                      o_rd_valid;
	logic                      o_overflow;

	// Expected events per channel, in index order
	dsi3_pkg::pdcm_event_t exp_q0 [$];
	dsi3_pkg::pdcm_event_t exp_q1 [$];

	string test_name;
	int    errors;
	int    checks;

	dsi3_pdcm_top dut (
		.clk_rst       (clk_rst),
		.i_rst_n       (i_rst_n),
		.i_cfg         (i_cfg),
		.i_frame_start (i_frame_start),
		.i_abort       (i_abort),
		.i_rx_strobe   (i_rx_strobe),
		.i_rd_en       (i_rd_en),
		.o_busy        (o_busy),
		.o_rd_evt      (o_rd_evt),
		.o_rd_valid    (o_rd_valid),
		.o_overflow    (o_overflow)
	);

	initial clk_rst = 1'b0;
	always #50 clk_rst = ~clk_rst;

	function automatic dsi3_pkg::pdcm_event_t expected_event(input int chan, input int idx,
			input logic rx);
		dsi3_pkg::pdcm_event_t e;
		e.channel = dsi3_pkg::chan_t'(chan);
		e.index   = dsi3_pkg::frame_idx_t'(idx);
		e.rx_seen = rx;
		return e;
	endfunction

	task automatic push_expected(input int chan, input int idx, input logic rx);
		if (chan == 0)
			exp_q0.push_back(expected_event(chan, idx, rx));
		else
			exp_q1.push_back(expected_event(chan, idx, rx));
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
		errors++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_rst);
	endtask

	// Config and start pulse reach the DUT on the same edge
	task automatic start_frames(input logic [`DSI3_CHANNELS-1:0] mask, input int periods);
		@(posedge clk_rst);
		i_cfg.period_us   <= dsi3_pkg::data_t'(PERIOD_US);
		i_cfg.frame_count <= dsi3_pkg::frame_idx_t'(periods);
		i_frame_start     <= mask;
		@(posedge clk_rst);
		i_frame_start     <= '0;
	endtask

	task automatic strobe_rx(input int chan);
		@(posedge clk_rst);
		i_rx_strobe[chan] <= 1'b1;
		@(posedge clk_rst);
		i_rx_strobe[chan] <= 1'b0;
	endtask

	// Wait for the oldest log entry, check it against its channel queue, then pop it
	task automatic pop_and_check(input int max_wait);
		dsi3_pkg::pdcm_event_t got;
		dsi3_pkg::pdcm_event_t exp_e;
		int                    waited;
		waited = 0;
		@(negedge clk_rst);
		while (!o_rd_valid && waited < max_wait) begin
			@(negedge clk_rst);
			waited++;
		end
		checks++;
		if (!o_rd_valid) begin
			$display("%s: no event reached the log within %0d cycles", test_name, max_wait);
			errors++;
		end else begin
			got = o_rd_evt;
			if ((got.channel == 0 && exp_q0.size() == 0) ||
					(got.channel == 1 && exp_q1.size() == 0)) begin
				$display("%s: unexpected event %h in the log", test_name, got);
				errors++;
			end else begin
				exp_e = (got.channel == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
				if (got !== exp_e)
					report_mismatch("log event", 32'(exp_e), 32'(got));
			end
			@(posedge clk_rst);
			i_rd_en <= 1'b1;
			@(posedge clk_rst);
			i_rd_en <= 1'b0;
		end
	endtask

	task automatic wait_idle(input logic [`DSI3_CHANNELS-1:0] mask, input int max_wait);
		int waited;
		waited = 0;
		@(negedge clk_rst);
		while ((o_busy & mask) != '0 && waited < max_wait) begin
			@(negedge clk_rst);
			waited++;
		end
		checks++;
		if ((o_busy & mask) != '0) begin
			$display("%s: busy still high after %0d cycles", test_name, max_wait);
			errors++;
		end
	endtask

	// Every expected event was seen and the log holds nothing more
	task automatic expect_no_pending();
		checks++;
		if (exp_q0.size() + exp_q1.size() != 0)
			report_mismatch("missing events", 32'd0, 32'(exp_q0.size() + exp_q1.size()));
		@(negedge clk_rst);
		checks++;
		if (o_rd_valid) begin
			$display("%s: extra event %h left in the log", test_name, o_rd_evt);
			errors++;
		end
	endtask

	task automatic test_reset();
		test_name = "reset";
		@(negedge clk_rst);
		checks++;
		if (o_busy !== '0 || o_rd_valid !== 1'b0 || o_overflow !== 1'b0)
			report_mismatch("busy/valid/overflow", 32'd0, {o_busy, o_rd_valid, o_overflow});
	endtask

	// Rx in periods 0 and 2
	task automatic test_single_frame();
		test_name = "single_frame";
		push_expected(0, 0, 1'b1);
		push_expected(0, 1, 1'b0);
		push_expected(0, 2, 1'b1);
		start_frames(2'b01, 3);
		idle_cycles(2 * US_CYCLES);
		strobe_rx(0);
		pop_and_check(EVT_WAIT);
		pop_and_check(EVT_WAIT);
		// Previous event was seen near its timeout, so 6 us later lies in the next period
		idle_cycles(6 * US_CYCLES);
		strobe_rx(0);
		pop_and_check(EVT_WAIT);
		wait_idle(2'b01, EVT_WAIT);
		expect_no_pending();
	endtask

	task automatic test_concurrent();
		test_name = "concurrent";
		for (int i = 0; i < 4; i++) begin
			push_expected(0, i, 1'b0);
			push_expected(1, i, 1'b0);
		end
		start_frames(2'b11, 4);
		repeat (8) pop_and_check(EVT_WAIT);
		wait_idle(2'b11, EVT_WAIT);
		expect_no_pending();
		checks++;
		if (o_overflow !== 1'b0)
			report_mismatch("overflow", 32'd0, 32'(o_overflow));
	endtask

	task automatic test_abort();
		test_name = "abort";
		push_expected(1, 0, 1'b0);
		push_expected(1, 1, 1'b0);
		start_frames(2'b10, 6);
		pop_and_check(EVT_WAIT);
		pop_and_check(EVT_WAIT);
		@(posedge clk_rst);
		i_abort <= 2'b10;
		@(posedge clk_rst);
		i_abort <= 2'b00;
		@(negedge clk_rst);
		checks++;
		if (o_busy[1] !== 1'b0)
			report_mismatch("busy after abort", 32'd0, 32'(o_busy[1]));
		// Nothing more may be logged once the frame is stopped
		checks++;
		for (int i = 0; i < EVT_WAIT; i++) begin
			@(negedge clk_rst);
			if (o_rd_valid) begin
				$display("%s: event %h logged after the abort", test_name, o_rd_evt);
				errors++;
				break;
			end
		end
		expect_no_pending();
	endtask

	task automatic test_overflow();
		int kept;
		test_name = "overflow";
		kept      = 0;
		for (int i = 0; i < 10; i++) begin
			push_expected(0, i, 1'b0);
			push_expected(1, i, 1'b0);
		end
		start_frames(2'b11, 10);
		wait_idle(2'b11, 12 * PERIOD_US * US_CYCLES);
		checks++;
		if (o_overflow !== 1'b1)
			report_mismatch("overflow", 32'd1, 32'(o_overflow));
		@(negedge clk_rst);
		while (o_rd_valid && kept < 2 * `DSI3_LOG_DEPTH) begin
			pop_and_check(1);
			kept++;
			@(negedge clk_rst);
		end
		checks++;
		if (kept != `DSI3_LOG_DEPTH)
			report_mismatch("kept entries", 32'(`DSI3_LOG_DEPTH), 32'(kept));
		// Dropped tail of each frame stays unmatched
		exp_q0.delete();
		exp_q1.delete();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_rst);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		errors        = 0;
		checks        = 0;
		test_name     = "init";
		i_rst_n       = 1'b0;
		i_cfg         = '0;
		i_frame_start = '0;
		i_abort       = '0;
		i_rx_strobe   = '0;
		i_rd_en       = 1'b0;
		idle_cycles(2);
		i_rst_n <= 1'b1;
		test_reset();
		test_single_frame();
		test_concurrent();
		test_abort();
		test_overflow();
		idle_cycles(2);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/dsi3_pkg.sv
hw/period_counter.sv
hw/pdcm_sequencer.sv
hw/event_arbiter.sv
hw/event_log.sv
hw/dsi3_pdcm_top.sv
sim/tb_dsi3_pdcm.sv
